//--- src/memPkg.sv
`default_nettype none

package memPkg;

    localparam int DataWidth = 32;              // word size
    localparam int AddrWidth = 32;              // byte address size
    localparam int StrbWidth = DataWidth / 8;   // one strobe per byte lane

    typedef logic [DataWidth-1:0] word_t;       // instruction, register or bus word
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [StrbWidth-1:0] strb_t;
    typedef logic [1:0]           axiResp_t;    // OKAY, EXOKAY, SLVERR, DECERR

    // op codes as the core's decoder issues them
    typedef enum logic [3:0] {
        OpNone = 4'd0,
        OpLb   = 4'd1,
        OpLh   = 4'd2,
        OpLw   = 4'd3,
        OpLbu  = 4'd4,
        OpLhu  = 4'd5,
        OpSb   = 4'd6,
        OpSh   = 4'd7,
        OpSw   = 4'd8
    } memOp_t;

    // one pass per instruction, RETIRE is the only unfrozen state
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        DATA   = 2'd1,
        ACCESS = 2'd2,
        RETIRE = 2'd3
    } handlerState_t;

    typedef struct packed {
        logic   isLoad;
        logic   isStore;
        memOp_t op;
        addr_t  addr;
        word_t  wdata;      // already narrowed to the low lanes
        strb_t  wstrb;
    } memReq_t;

    typedef struct packed {
        logic  valid;       // held until done
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } busReq_t;

    typedef struct packed {
        logic  done;        // single cycle pulse
        word_t rdata;       // valid with done on reads
    } busRsp_t;

    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        word_t wdata;
        strb_t wstrb;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        logic  rready;
    } axiM2S_t;

    typedef struct packed {
        logic     awready;
        logic     wready;
        logic     bvalid;
        axiResp_t bresp;
        logic     arready;
        logic     rvalid;
        word_t    rdata;
        axiResp_t rresp;
    } axiS2M_t;

endpackage

`default_nettype wire

//--- src/memReqDecode.sv
`timescale 1ns/1ps
`default_nettype none

module memReqDecode (
    input  wire logic           memRead_i,
    input  wire logic           memWrite_i,
    input  wire logic           memSource_i,    // high selects the FPU register file
    input  wire memPkg::memOp_t memOp_i,
    input  wire memPkg::addr_t  aluAddress_i,
    input  wire memPkg::word_t  regData_i,
    input  wire memPkg::word_t  fpuData_i,
    output memPkg::memReq_t     req_o
);

    memPkg::word_t srcData;     // store data before narrowing
    memPkg::word_t storeData;
    memPkg::strb_t storeStrb;

    assign srcData = memSource_i ? fpuData_i : regData_i;

    // narrow to the low lanes with matching strobes
    always_comb begin
        case (memOp_i)
            memPkg::OpSb: begin
                storeData = {{(memPkg::DataWidth-8){1'b0}}, srcData[7:0]};
                storeStrb = 4'b0001;
            end
            memPkg::OpSh: begin
                storeData = {{(memPkg::DataWidth-16){1'b0}}, srcData[15:0]};
                storeStrb = 4'b0011;
            end
            memPkg::OpSw: begin
                storeData = srcData;
                storeStrb = 4'b1111;
            end
            default: begin
                // bad store op writes a zero word
                storeData = '0;
                storeStrb = 4'b1111;
            end
        endcase
    end

    always_comb begin
        req_o.isStore = memWrite_i;
        req_o.isLoad  = memRead_i && !memWrite_i;   // write wins over read
        req_o.op      = memOp_i;
        req_o.addr    = aluAddress_i;
        req_o.wdata   = storeData;
        req_o.wstrb   = storeStrb;
    end

endmodule

`default_nettype wire

//--- src/memSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module memSequencer (
    input  wire logic            clk,
    input  wire logic            nrst,
    input  wire memPkg::addr_t   pc_i,
    input  wire memPkg::memReq_t req_i,
    output memPkg::busReq_t      busReq_o,
    input  wire memPkg::busRsp_t busRsp_i,
    output memPkg::word_t        instruction_o,
    output memPkg::word_t        regData_o,
    output logic                 freeze_o
);

    memPkg::handlerState_t state;
    memPkg::handlerState_t stateNext;
    memPkg::memReq_t       accReq;      // access fields taken in DATA
    logic                  busDone;

    // sign or zero extension of the low lanes
    function automatic memPkg::word_t formatLoad(
        input memPkg::memOp_t op,
        input memPkg::word_t  raw
    );
        memPkg::word_t result;
        case (op)
            memPkg::OpLb:  result = {{24{raw[7]}}, raw[7:0]};
            memPkg::OpLh:  result = {{16{raw[15]}}, raw[15:0]};
            memPkg::OpLw:  result = raw;
            memPkg::OpLbu: result = {24'b0, raw[7:0]};
            memPkg::OpLhu: result = {16'b0, raw[15:0]};
            default:       result = '0;     // not a load op
        endcase
        return result;
    endfunction

    assign busDone = busRsp_i.done;

    always_comb begin
        stateNext = state;
        case (state)
            memPkg::FETCH: begin
                if (busDone) begin
                    stateNext = memPkg::DATA;
                end
            end
            memPkg::DATA: begin
                // single decision cycle on the core's controls
                if (req_i.isLoad || req_i.isStore) begin
                    stateNext = memPkg::ACCESS;
                end else begin
                    stateNext = memPkg::RETIRE;
                end
            end
            memPkg::ACCESS: begin
                if (busDone) begin
                    stateNext = memPkg::RETIRE;
                end
            end
            memPkg::RETIRE: stateNext = memPkg::FETCH;
            default:        stateNext = memPkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state         <= memPkg::FETCH;
            instruction_o <= '0;
            regData_o     <= '0;
        end else begin
            state <= stateNext;
            if (state == memPkg::FETCH && busDone) begin
                instruction_o <= busRsp_i.rdata;
            end
            if (state == memPkg::ACCESS && busDone && accReq.isLoad) begin
                regData_o <= formatLoad(accReq.op, busRsp_i.rdata);  // holds otherwise
            end
        end
    end

    // core may move its inputs once ACCESS has started
    always_ff @(posedge clk) begin
        if (state == memPkg::DATA) begin
            accReq <= req_i;
        end
    end

    always_comb begin
        busReq_o = '0;
        case (state)
            memPkg::FETCH: begin
                busReq_o.valid = 1'b1;
                busReq_o.addr  = pc_i;      // pc is steady while frozen
            end
            memPkg::ACCESS: begin
                busReq_o.valid = 1'b1;
                busReq_o.write = accReq.isStore;
                busReq_o.addr  = accReq.addr;
                busReq_o.wdata = accReq.wdata;
                busReq_o.wstrb = accReq.wstrb;
            end
            default: busReq_o = '0;
        endcase
    end

    assign freeze_o = (state != memPkg::RETIRE);

    assert property (@(posedge clk) disable iff (!nrst)
        busReq_o.valid && !busRsp_i.done |=> $stable(busReq_o))
        else $error("memSequencer: bus request changed before done");

endmodule

`default_nettype wire

//--- src/memBusMaster.sv
`timescale 1ns/1ps
`default_nettype none

module memBusMaster (
    input  wire logic            clk,
    input  wire logic            nrst,
    input  wire memPkg::busReq_t busReq_i,
    output memPkg::busRsp_t      busRsp_o,
    output memPkg::axiM2S_t      axiM_o,
    input  wire memPkg::axiS2M_t axiS_i
);

    typedef enum logic [1:0] {
        BusIdle  = 2'd0,
        BusWrite = 2'd1,    // AW, W and B in flight
        BusRead  = 2'd2,    // AR then R
        BusDone  = 2'd3     // done pulse
    } busState_t;

    busState_t     state;
    logic          awvalidQ;
    logic          wvalidQ;
    logic          breadyQ;
    logic          arvalidQ;
    logic          rreadyQ;
    memPkg::addr_t addrQ;       // shared by AW and AR
    memPkg::word_t wdataQ;
    memPkg::strb_t wstrbQ;
    memPkg::word_t rdataQ;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state    <= BusIdle;
            awvalidQ <= 1'b0;
            wvalidQ  <= 1'b0;
            breadyQ  <= 1'b0;
            arvalidQ <= 1'b0;
            rreadyQ  <= 1'b0;
        end else begin
            case (state)
                BusIdle: begin
                    if (busReq_i.valid && busReq_i.write) begin
                        awvalidQ <= 1'b1;   // address and data go out together
                        wvalidQ  <= 1'b1;
                        breadyQ  <= 1'b1;
                        state    <= BusWrite;
                    end else if (busReq_i.valid) begin
                        arvalidQ <= 1'b1;
                        state    <= BusRead;
                    end
                end
                BusWrite: begin
                    if (awvalidQ && axiS_i.awready) begin
                        awvalidQ <= 1'b0;
                    end
                    if (wvalidQ && axiS_i.wready) begin
                        wvalidQ <= 1'b0;
                    end
                    if (breadyQ && axiS_i.bvalid) begin
                        breadyQ <= 1'b0;    // bresp ignored
                        state   <= BusDone;
                    end
                end
                BusRead: begin
                    if (arvalidQ && axiS_i.arready) begin
                        arvalidQ <= 1'b0;
                        rreadyQ  <= 1'b1;
                    end
                    if (rreadyQ && axiS_i.rvalid) begin
                        rreadyQ <= 1'b0;
                        state   <= BusDone;
                    end
                end
                default: state <= BusIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BusIdle && busReq_i.valid) begin
            addrQ  <= busReq_i.addr;
            wdataQ <= busReq_i.wdata;
            wstrbQ <= busReq_i.wstrb;
        end
        if (rreadyQ && axiS_i.rvalid) begin
            rdataQ <= axiS_i.rdata;     // rresp ignored
        end
    end

    always_comb begin
        axiM_o.awvalid = awvalidQ;
        axiM_o.awaddr  = addrQ;
        axiM_o.wvalid  = wvalidQ;
        axiM_o.wdata   = wdataQ;
        axiM_o.wstrb   = wstrbQ;
        axiM_o.bready  = breadyQ;
        axiM_o.arvalid = arvalidQ;
        axiM_o.araddr  = addrQ;
        axiM_o.rready  = rreadyQ;
    end

    assign busRsp_o.done  = (state == BusDone);
    assign busRsp_o.rdata = rdataQ;

    // a slave response only answers the transaction in flight
    property answerInFlight(valid, ready);
        @(posedge clk) disable iff (!nrst)
        valid |-> ready;
    endproperty

    assert property (answerInFlight(axiS_i.bvalid, axiM_o.bready))
        else $error("memBusMaster: bvalid without a write in flight");
    assert property (answerInFlight(axiS_i.rvalid, axiM_o.rready))
        else $error("memBusMaster: rvalid without a read in flight");

endmodule

`default_nettype wire

//--- src/memoryHandler.sv
`timescale 1ns/1ps
`default_nettype none

module memoryHandler (
    input  wire logic            clk,
    input  wire logic            nrst,
    input  wire memPkg::addr_t   pc_i,
    input  wire logic            memRead_i,
    input  wire logic            memWrite_i,
    input  wire memPkg::memOp_t  memOp_i,
    input  wire logic            memSource_i,   // store from FPU registers
    input  wire memPkg::addr_t   aluAddress_i,
    input  wire memPkg::word_t   regData_i,
    input  wire memPkg::word_t   fpuData_i,
    output memPkg::word_t        instruction_o,
    output memPkg::addr_t        pcOut_o,
    output memPkg::word_t        regData_o,
    output logic                 freeze_o,
    output memPkg::axiM2S_t      axiM_o,
    input  wire memPkg::axiS2M_t axiS_i
);

    memPkg::memReq_t memReq;
    memPkg::busReq_t busReq;
    memPkg::busRsp_t busRsp;

    assign pcOut_o = pc_i;  // passes straight through

    memReqDecode memReqDecode_inst (
        .memRead_i    (memRead_i),
        .memWrite_i   (memWrite_i),
        .memSource_i  (memSource_i),
        .memOp_i      (memOp_i),
        .aluAddress_i (aluAddress_i),
        .regData_i    (regData_i),
        .fpuData_i    (fpuData_i),
        .req_o        (memReq)
    );

    memSequencer memSequencer_inst (
        .clk           (clk),
        .nrst          (nrst),
        .pc_i          (pc_i),
        .req_i         (memReq),
        .busReq_o      (busReq),
        .busRsp_i      (busRsp),
        .instruction_o (instruction_o),
        .regData_o     (regData_o),
        .freeze_o      (freeze_o)
    );

    memBusMaster memBusMaster_inst (
        .clk      (clk),
        .nrst     (nrst),
        .busReq_i (busReq),
        .busRsp_o (busRsp),
        .axiM_o   (axiM_o),
        .axiS_i   (axiS_i)
    );

endmodule

`default_nettype wire

//--- sim/axiMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module axiMemModel #(
    parameter int Depth = 256,
    parameter int Seed  = 32'h6d5a
) (
    input  wire logic            clk,
    input  wire logic            nrst,
    input  wire memPkg::axiM2S_t axiM_i,
    output memPkg::axiS2M_t      axiS_o
);

    localparam int IdxBits = $clog2(Depth);

    memPkg::word_t mem [Depth];     // preloaded by the testbench
    integer        seed = Seed;
    logic [1:0]    awWait;
    logic [1:0]    wWait;
    logic [1:0]    arWait;
    logic [1:0]    rWait;
    logic          awGot;
    logic          wGot;
    logic          arGot;
    memPkg::addr_t awAddr;
    memPkg::word_t wData;
    memPkg::strb_t wStrb;
    memPkg::addr_t arAddr;
    memPkg::word_t merged;

    // 0 to 3 wait states
    function automatic logic [1:0] drawWait();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    always @(posedge clk) begin
        if (!nrst) begin
            axiS_o <= '0;
            awGot  <= 1'b0;
            wGot   <= 1'b0;
            arGot  <= 1'b0;
            awWait <= drawWait();
            wWait  <= drawWait();
            arWait <= drawWait();
            rWait  <= drawWait();
        end else begin
            if (axiM_i.awvalid && axiS_o.awready) begin
                axiS_o.awready <= 1'b0;
                awAddr <= axiM_i.awaddr;
                awGot  <= 1'b1;
                awWait <= drawWait();
            end else if (axiM_i.awvalid && !awGot) begin
                if (awWait == 2'd0) begin
                    axiS_o.awready <= 1'b1;
                end else begin
                    awWait <= awWait - 2'd1;
                end
            end
            if (axiM_i.wvalid && axiS_o.wready) begin
                axiS_o.wready <= 1'b0;
                wData <= axiM_i.wdata;
                wStrb <= axiM_i.wstrb;
                wGot  <= 1'b1;
                wWait <= drawWait();
            end else if (axiM_i.wvalid && !wGot) begin
                if (wWait == 2'd0) begin
                    axiS_o.wready <= 1'b1;
                end else begin
                    wWait <= wWait - 2'd1;
                end
            end
            // merge strobed bytes and respond once address and data are in
            if (awGot && wGot) begin
                merged = mem[awAddr[IdxBits+1:2]];
                for (int b = 0; b < 4; b++) begin
                    if (wStrb[b]) begin
                        merged[8*b +: 8] = wData[8*b +: 8];
                    end
                end
                mem[awAddr[IdxBits+1:2]] <= merged;
                awGot <= 1'b0;
                wGot  <= 1'b0;
                axiS_o.bvalid <= 1'b1;
            end else if (axiS_o.bvalid && axiM_i.bready) begin
                axiS_o.bvalid <= 1'b0;
            end
            if (axiM_i.arvalid && axiS_o.arready) begin
                axiS_o.arready <= 1'b0;
                arAddr <= axiM_i.araddr;
                arGot  <= 1'b1;
                arWait <= drawWait();
            end else if (axiM_i.arvalid && !arGot) begin
                if (arWait == 2'd0) begin
                    axiS_o.arready <= 1'b1;
                end else begin
                    arWait <= arWait - 2'd1;
                end
            end
            if (arGot && !axiS_o.rvalid) begin
                if (rWait == 2'd0) begin
                    axiS_o.rvalid <= 1'b1;
                    axiS_o.rdata  <= mem[arAddr[IdxBits+1:2]];
                    arGot <= 1'b0;
                    rWait <= drawWait();
                end else begin
                    rWait <= rWait - 2'd1;
                end
            end else if (axiS_o.rvalid && axiM_i.rready) begin
                axiS_o.rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/memoryHandler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memoryHandler_tb;

    localparam int Depth      = 256;
    localparam int IdxBits    = $clog2(Depth);
    localparam int SeedInit   = 32'h6d5a;
    localparam int RandInstr  = 16;
    localparam int TotalInstr = 3 + 3 + 3 + 6 + 6 + RandInstr;
    localparam int WorstInstr = 30;     // fetch plus access with 3 waits on every channel
    localparam int MaxCycles  = 8 + TotalInstr * WorstInstr + 100;

    logic            clk;
    logic            nrst;
    memPkg::addr_t   pc;
    logic            memRead;
    logic            memWrite;
    memPkg::memOp_t  memOp;
    logic            memSource;
    memPkg::addr_t   aluAddress;
    memPkg::word_t   regDataIn;
    memPkg::word_t   fpuData;
    memPkg::word_t   instruction;
    memPkg::addr_t   pcOut;
    memPkg::word_t   regDataOut;
    logic            freeze;
    memPkg::axiM2S_t axiM;
    memPkg::axiS2M_t axiS;
    memPkg::word_t   shadow [Depth];    // expected memory contents
    integer          seed;
    int              cycleCount = 0;

    memoryHandler memoryHandler_inst (
        .clk           (clk),
        .nrst          (nrst),
        .pc_i          (pc),
        .memRead_i     (memRead),
        .memWrite_i    (memWrite),
        .memOp_i       (memOp),
        .memSource_i   (memSource),
        .aluAddress_i  (aluAddress),
        .regData_i     (regDataIn),
        .fpuData_i     (fpuData),
        .instruction_o (instruction),
        .pcOut_o       (pcOut),
        .regData_o     (regDataOut),
        .freeze_o      (freeze),
        .axiM_o        (axiM),
        .axiS_i        (axiS)
    );

    axiMemModel #(.Depth(Depth), .Seed(SeedInit)) memModel (
        .clk    (clk),
        .nrst   (nrst),
        .axiM_i (axiM),
        .axiS_o (axiS)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("TIMEOUT: the DUT did not finish all instructions in %0d cycles",
                     MaxCycles);
            $display("Test failures found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic checkWord(input string what, input memPkg::word_t got,
                             input memPkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic checkFreeze(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // sign or zero extension of the low lanes
    function automatic memPkg::word_t extendLoad(input memPkg::memOp_t op,
                                                 input memPkg::word_t w);
        case (op)
            memPkg::OpLb:  return memPkg::word_t'($signed(w[7:0]));
            memPkg::OpLh:  return memPkg::word_t'($signed(w[15:0]));
            memPkg::OpLw:  return w;
            memPkg::OpLbu: return memPkg::word_t'(w[7:0]);
            memPkg::OpLhu: return memPkg::word_t'(w[15:0]);
            default:       return '0;
        endcase
    endfunction

    // new low lanes over the old word
    function automatic memPkg::word_t mergeStore(input memPkg::memOp_t op,
                                                 input memPkg::word_t old,
                                                 input memPkg::word_t src);
        case (op)
            memPkg::OpSb: return {old[31:8], src[7:0]};
            memPkg::OpSh: return {old[31:16], src[15:0]};
            memPkg::OpSw: return src;
            default:      return '0;
        endcase
    endfunction

    task automatic setWord(input int idx, input memPkg::word_t w);
        memModel.mem[idx] = w;
        shadow[idx]       = w;
    endtask

    // starts and ends on a falling edge, the last one just after retire
    task automatic runInstr(input memPkg::addr_t pcVal, input logic rd, input logic wr,
                            input memPkg::memOp_t op, input logic src,
                            input memPkg::addr_t addr, input memPkg::word_t rData,
                            input memPkg::word_t fData);
        pc         = pcVal;
        memRead    = rd;
        memWrite   = wr;
        memOp      = op;
        memSource  = src;
        aluAddress = addr;
        regDataIn  = rData;
        fpuData    = fData;
        @(negedge clk);
        while (freeze) begin
            @(negedge clk);
        end
        checkWord("instruction_o", instruction, shadow[pcVal[IdxBits+1:2]]);
        checkWord("pcOut_o", pcOut, pcVal);
        @(negedge clk);
        checkFreeze("freeze_o one cycle after retire", freeze, 1'b1);
    endtask

    task automatic idleInstr(input memPkg::addr_t pcVal);
        memPkg::word_t regBefore;
        regBefore = regDataOut;
        runInstr(pcVal, 1'b0, 1'b0, memPkg::OpNone, 1'b0, '0, 32'h1111_2222, 32'h3333_4444);
        checkWord("regData_o held without load", regDataOut, regBefore);
    endtask

    task automatic loadInstr(input memPkg::addr_t pcVal, input memPkg::memOp_t op,
                             input memPkg::addr_t addr);
        memPkg::word_t expReg;
        expReg = extendLoad(op, shadow[addr[IdxBits+1:2]]);
        runInstr(pcVal, 1'b1, 1'b0, op, 1'b0, addr, 32'h5555_aaaa, 32'haaaa_5555);
        checkWord("regData_o after load", regDataOut, expReg);
    endtask

    task automatic storeInstr(input memPkg::addr_t pcVal, input memPkg::memOp_t op,
                              input logic src, input memPkg::addr_t addr,
                              input memPkg::word_t rData, input memPkg::word_t fData);
        int            idx;
        memPkg::word_t regBefore;
        memPkg::word_t expWord;
        idx       = addr[IdxBits+1:2];
        regBefore = regDataOut;
        expWord   = mergeStore(op, shadow[idx], src ? fData : rData);
        runInstr(pcVal, 1'b0, 1'b1, op, src, addr, rData, fData);
        shadow[idx] = expWord;
        checkWord("memory word after store", memModel.mem[idx], expWord);
        checkWord("regData_o held over store", regDataOut, regBefore);
    endtask

    task automatic fetchRetire();
        idleInstr(32'h0000_0000);
        idleInstr(32'h0000_0004);
        idleInstr(32'h0000_03fc);  // last word
    endtask

    task automatic signedLoads();
        setWord(32'h30, 32'h9e5c_80f1);     // sign bits set in byte, half and word
        loadInstr(32'h0000_0010, memPkg::OpLb, 32'h0000_00c0);
        loadInstr(32'h0000_0014, memPkg::OpLh, 32'h0000_00c0);
        loadInstr(32'h0000_0018, memPkg::OpLw, 32'h0000_00c0);
    endtask

    task automatic unsignedLoads();
        setWord(32'h31, 32'hb3a4_c2d7);
        loadInstr(32'h0000_0020, memPkg::OpLbu, 32'h0000_00c4);
        loadInstr(32'h0000_0024, memPkg::OpLhu, 32'h0000_00c4);
        loadInstr(32'h0000_0028, memPkg::OpNone, 32'h0000_00c4);  // not a load op
    endtask

    // each store lands on its own preloaded word and is read back over the bus
    task automatic strobedStores(input logic src);
        memPkg::addr_t  addr;
        memPkg::memOp_t op;
        for (int k = 0; k < 3; k++) begin
            op   = memPkg::memOp_t'(4'(6 + k));
            addr = (src ? 32'h0000_0240 : 32'h0000_0200) + 4 * k;
            setWord(addr[IdxBits+1:2], 32'hcafe_f00d);
            storeInstr(32'h0000_0040 + 8 * k, op, src, addr, 32'h1357_9bdf, 32'hfdb9_7531);
            loadInstr(32'h0000_0044 + 8 * k, memPkg::OpLw, addr);
        end
    endtask

    task automatic randomTraffic();
        logic [31:0]    r;
        memPkg::memOp_t op;
        memPkg::addr_t  pcVal;
        memPkg::addr_t  addr;
        memPkg::word_t  rData;
        memPkg::word_t  fData;
        for (int n = 0; n < RandInstr; n++) begin
            r     = $random(seed);
            rData = $random(seed);
            fData = $random(seed);
            op    = memPkg::memOp_t'(4'(1 + r[31:29]));
            pcVal = {22'b0, r[7:0], 2'b00};
            addr  = {22'b0, r[17:8]};   // low bits may be unaligned
            if (op >= memPkg::OpSb) begin
                storeInstr(pcVal, op, r[18], addr, rData, fData);
            end else begin
                loadInstr(pcVal, op, addr);
            end
        end
    endtask

    initial begin
        seed       = SeedInit;
        nrst       = 1'b0;
        pc         = '0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memOp      = memPkg::OpNone;
        memSource  = 1'b0;
        aluAddress = '0;
        regDataIn  = '0;
        fpuData    = '0;
        for (int i = 0; i < Depth; i++) begin
            setWord(i, (i * 32'h0101_0101) ^ 32'ha5c3_965e);
        end
        repeat (8) @(negedge clk);
        nrst = 1'b1;
        checkFreeze("freeze_o after reset", freeze, 1'b1);
        fetchRetire();
        signedLoads();
        unsignedLoads();
        strobedStores(1'b0);
        strobedStores(1'b1);
        randomTraffic();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- memoryHandler.f
src/memPkg.sv
src/memReqDecode.sv
src/memSequencer.sv
src/memBusMaster.sv
src/memoryHandler.sv
sim/axiMemModel.sv
sim/memoryHandler_tb.sv
